//--- project.f
+incdir+rtl
rtl/rfm_pkg.sv
rtl/rfm.sv
rtl/wr_arbiter.sv
rtl/exec_unit.sv
rtl/apb_host_port.sv
rtl/rf_subsys_top.sv
verification/tb_rf_subsys.sv

//--- rtl/apb_host_port.sv
`timescale 1ns/100ps
`include "rfm_macros.svh"

module apb_host_port
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  logic [`APB_ADDR_W-1:0]   paddr,
   input  logic [`RF_WIDTH-1:0]     pwdata,
   output logic [`RF_WIDTH-1:0]     prdata,
   output logic                     pready,
   output logic                     pslverr,
   output rfm_pkg::rf_wr_req_t      host_req,
   input  logic                     host_gnt,
   output logic [`RF_ADDR_SIZE-1:0] rt,
   input  logic [`RF_WIDTH-1:0]     dt,
   output rfm_pkg::cmd_word_u       cmd,
   output logic                     cmd_valid,
   input  rfm_pkg::stat_t           stat
);

   import rfm_pkg::*;

   // Bus phases.
   logic setup;
   logic access;

   // Address decode.
   logic [`APB_ADDR_W-1:0] win_ofs;
   logic                   win_hit;
   logic                   cmd_hit;
   logic                   stat_hit;

   // Command checks.
   logic op_legal;
   logic cmd_ok;

   // Read data before the output register.
   logic [`RF_WIDTH-1:0] rd_mux;

   assign setup  = psel & ~penable;
   assign access = psel & penable;

   //////////////////////////////////////////////////////////////////////
   // Address decode.
   //////////////////////////////////////////////////////////////////////

   // Window is 16 aligned words from the base.
   assign win_ofs  = paddr - `RF_WIN_BASE;
   assign win_hit  = (win_ofs < (1 << (`RF_ADDR_SIZE + 2))) && (win_ofs[1:0] == 2'b00);
   assign cmd_hit  = (paddr == `RF_CMD_OFS);
   assign stat_hit = (paddr == `RF_STAT_OFS);

   // Register index from the word offset.
   assign rt = win_ofs[`RF_ADDR_SIZE+1:2];

   //////////////////////////////////////////////////////////////////////
   // Host register write.
   //////////////////////////////////////////////////////////////////////

   // Request held for the whole write access phase.
   // It drops once the grant ends the transfer.
   always_comb
   begin
      host_req       = '0;
      host_req.valid = access & pwrite & win_hit;
      host_req.addr  = rt;
      host_req.data  = pwdata;
   end

   //////////////////////////////////////////////////////////////////////
   // Command hand-off.
   //////////////////////////////////////////////////////////////////////

   // Command word taken straight from the bus.
   assign cmd = pwdata;

   // Opcode legality.
   always_comb
   begin
      case (cmd.r.opcode)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
         OP_MAC, OP_LDI, OP_LDHI:
         begin
            op_legal = 1'b1;
         end
         default:
         begin
            op_legal = 1'b0;
         end
      endcase
   end

   // Legal command write in access.
   assign cmd_ok = access & pwrite & cmd_hit & op_legal;

   // One cycle pulse, since pready ends the transfer with it.
   assign cmd_valid = cmd_ok & ~stat.busy;

   //////////////////////////////////////////////////////////////////////
   // Handshake and response.
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      pready  = 1'b0;
      pslverr = 1'b0;
      if (access)
      begin
         if (win_hit)
         begin
            // Writes wait for the write port.
            pready = pwrite ? host_gnt : 1'b1;
         end
         else if (cmd_ok)
         begin
            // Back-pressure while a command runs.
            pready = ~stat.busy;
         end
         else if (stat_hit && !pwrite)
         begin
            pready = 1'b1;
         end
         else
         begin
            // Unmapped, illegal opcode, status write or command read.
            pready  = 1'b1;
            pslverr = 1'b1;
         end
      end
   end

   // Read source select.
   assign rd_mux = win_hit  ? dt :
                   stat_hit ? stat : '0;

   // Read data captured at the end of setup.
   // Stable for the whole access phase.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         prdata <= '0;
      end
      else if (setup && !pwrite)
      begin
         prdata <= rd_mux;
      end
   end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/100ps
`include "rfm_macros.svh"

module exec_unit
(
   input  logic                     clk,
   input  logic                     reset,
   input  rfm_pkg::cmd_word_u       cmd,
   input  logic                     cmd_valid,
   output logic [`RF_ADDR_SIZE-1:0] ra,
   output logic [`RF_ADDR_SIZE-1:0] rb,
   output logic [`RF_ADDR_SIZE-1:0] rd,
   input  logic [`RF_WIDTH-1:0]     da,
   input  logic [`RF_WIDTH-1:0]     db,
   input  logic [`RF_WIDTH-1:0]     dd,
   output rfm_pkg::rf_wr_req_t      exec_req,
   input  logic                     exec_gnt,
   output rfm_pkg::stat_t           stat
);

   import rfm_pkg::*;

   // Accepted command.
   cmd_word_u cmd_q;

   // Control state.
   logic       busy;
   logic       req_valid;
   logic [7:0] count;

   // Result held for the write port.
   logic [`RF_ADDR_SIZE-1:0] req_addr;
   logic [`RF_WIDTH-1:0]     req_data;

   // Datapath.
   logic [`RF_WIDTH-1:0] product;
   logic [`RF_WIDTH-1:0] result;

   // Compute cycle is busy with no request out yet.
   logic compute;

   assign compute = busy & ~req_valid;

   //////////////////////////////////////////////////////////////////////
   // Operand select.
   //////////////////////////////////////////////////////////////////////

   assign ra = cmd_q.r.ra;
   assign rb = cmd_q.r.rb;

   // Destination field sits at the same bits in both formats.
   assign rd = cmd_q.r.rd;

   //////////////////////////////////////////////////////////////////////
   // Result.
   //////////////////////////////////////////////////////////////////////

   // Low half of the operand product.
   assign product = da * db;

   always_comb
   begin
      case (cmd_q.r.opcode)
         OP_ADD:  result = da + db;
         OP_SUB:  result = da - db;
         OP_AND:  result = da & db;
         OP_OR:   result = da | db;
         OP_XOR:  result = da ^ db;
         // Accumulate onto the old destination.
         OP_MAC:  result = dd + product;
         // Sign-extended immediate.
         OP_LDI:  result = {{16{cmd_q.i.imm16[15]}}, cmd_q.i.imm16};
         // New upper half, old lower half.
         OP_LDHI: result = {cmd_q.i.imm16, dd[15:0]};
         default: result = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // State.
   //////////////////////////////////////////////////////////////////////

   // Command payload and result registers.
   always_ff @(posedge clk)
   begin
      if (cmd_valid && !busy)
      begin
         cmd_q <= cmd;
      end
      if (compute)
      begin
         req_addr <= rd;
         req_data <= result;
      end
   end

   // Busy from acceptance to the result write.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         req_valid <= 1'b0;
         count     <= '0;
      end
      else if (cmd_valid && !busy)
      begin
         busy <= 1'b1;
      end
      else if (compute)
      begin
         req_valid <= 1'b1;
      end
      else if (req_valid && exec_gnt)
      begin
         // Result lands on this edge.
         req_valid <= 1'b0;
         busy      <= 1'b0;
         count     <= count + 8'd1;
      end
   end

   // Request towards the arbiter.
   always_comb
   begin
      exec_req       = '0;
      exec_req.valid = req_valid;
      exec_req.addr  = req_addr;
      exec_req.data  = req_data;
   end

   // Status word.
   always_comb
   begin
      stat       = '0;
      stat.busy  = busy;
      stat.count = count;
   end

endmodule

//--- rtl/rf_subsys_top.sv
`timescale 1ns/100ps
`include "rfm_macros.svh"

module rf_subsys_top
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`APB_ADDR_W-1:0] paddr,
   input  logic [`RF_WIDTH-1:0]   pwdata,
   output logic [`RF_WIDTH-1:0]   prdata,
   output logic                   pready,
   output logic                   pslverr
);

   import rfm_pkg::*;

   // Write requests and grants.
   rf_wr_req_t host_req;
   rf_wr_req_t exec_req;
   logic       host_gnt;
   logic       exec_gnt;

   // Register file write port.
   logic                     wen;
   logic [`RF_ADDR_SIZE-1:0] wa;
   logic [`RF_WIDTH-1:0]     din;

   // Register file read ports.
   logic [`RF_ADDR_SIZE-1:0] ra;
   logic [`RF_ADDR_SIZE-1:0] rb;
   logic [`RF_ADDR_SIZE-1:0] rd;
   logic [`RF_ADDR_SIZE-1:0] rt;
   logic [`RF_WIDTH-1:0]     da;
   logic [`RF_WIDTH-1:0]     db;
   logic [`RF_WIDTH-1:0]     dd;
   logic [`RF_WIDTH-1:0]     dt;

   // Command path and status.
   cmd_word_u cmd;
   logic      cmd_valid;
   stat_t     stat;

   //////////////////////////////////////////////////////////////////////
   // Host side.
   //////////////////////////////////////////////////////////////////////

   apb_host_port i_apb_host_port
   (
      .clk       (clk),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .host_req  (host_req),
      .host_gnt  (host_gnt),
      .rt        (rt),
      .dt        (dt),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .stat      (stat)
   );

   // Execute unit on ports a, b and d.
   exec_unit i_exec_unit
   (
      .clk       (clk),
      .reset     (reset),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .ra        (ra),
      .rb        (rb),
      .rd        (rd),
      .da        (da),
      .db        (db),
      .dd        (dd),
      .exec_req  (exec_req),
      .exec_gnt  (exec_gnt),
      .stat      (stat)
   );

   //////////////////////////////////////////////////////////////////////
   // Shared write port and storage.
   //////////////////////////////////////////////////////////////////////

   wr_arbiter i_wr_arbiter
   (
      .clk      (clk),
      .reset    (reset),
      .host_req (host_req),
      .exec_req (exec_req),
      .host_gnt (host_gnt),
      .exec_gnt (exec_gnt),
      .wen      (wen),
      .wa       (wa),
      .din      (din)
   );

   rfm
   #(
      .WIDTH     (`RF_WIDTH),
      .ADDR_SIZE (`RF_ADDR_SIZE)
   )
   i_rfm
   (
      .clk   (clk),
      .reset (reset),
      .wen   (wen),
      .wa    (wa),
      .ra    (ra),
      .rb    (rb),
      .rd    (rd),
      .rt    (rt),
      .din   (din),
      .da    (da),
      .db    (db),
      .dd    (dd),
      .dt    (dt)
   );

endmodule

//--- rtl/rfm.sv
`timescale 1ns/100ps

module rfm
#(
   parameter WIDTH     = 32,
   parameter ADDR_SIZE = 4
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wen,
   input  logic [ADDR_SIZE-1:0] wa,
   input  logic [ADDR_SIZE-1:0] ra,
   input  logic [ADDR_SIZE-1:0] rb,
   input  logic [ADDR_SIZE-1:0] rd,
   input  logic [ADDR_SIZE-1:0] rt,
   input  logic [WIDTH-1:0]     din,
   output logic [WIDTH-1:0]     da,
   output logic [WIDTH-1:0]     db,
   output logic [WIDTH-1:0]     dd,
   output logic [WIDTH-1:0]     dt
);

   // Number of registers.
   localparam int NUM_REGS = 1 << ADDR_SIZE;

   // Register storage.
   logic [WIDTH-1:0] reg_array [0:NUM_REGS-1];

   // Whole array cleared on reset.
   // One register written per edge.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < NUM_REGS; i++)
         begin
            reg_array[i] <= '0;
         end
      end
      else if (wen)
      begin
         reg_array[wa] <= din;
      end
   end

   // Four combinational read ports.
   // A write shows up the cycle after its edge.
   assign da = reg_array[ra];
   assign db = reg_array[rb];
   assign dd = reg_array[rd];
   assign dt = reg_array[rt];

endmodule

//--- rtl/rfm_macros.svh
`ifndef RFM_MACROS_SVH
`define RFM_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Register file geometry.
//////////////////////////////////////////////////////////////////////

// Data width of every register.
`define RF_WIDTH 32

// Register address bits, 16 registers.
`define RF_ADDR_SIZE 4

//////////////////////////////////////////////////////////////////////
// APB register map.
//////////////////////////////////////////////////////////////////////

// Byte address width on the APB side.
`define APB_ADDR_W 12

// Register window, register n at byte offset 4*n.
`define RF_WIN_BASE 12'h000

// Command register, write only.
`define RF_CMD_OFS 12'h040

// Status register, read only.
`define RF_STAT_OFS 12'h044

`endif

//--- rtl/rfm_pkg.sv
`include "rfm_macros.svh"

package rfm_pkg;

   // Command opcodes.
   // Codes 6, 7 and 10 to 15 are illegal.
   typedef enum logic [3:0]
   {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_MAC  = 4'd5,
      OP_LDI  = 4'd8,
      OP_LDHI = 4'd9
   } opcode_e;

   // Register-register format.
   typedef struct packed
   {
      opcode_e     opcode;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [15:0] unused;
   } cmd_reg_t;

   // Immediate format.
   typedef struct packed
   {
      opcode_e     opcode;
      logic [3:0]  rd;
      logic [7:0]  unused;
      logic [15:0] imm16;
   } cmd_imm_t;

   // One command word, two views.
   // The opcode picks which view is meaningful.
   typedef union packed
   {
      cmd_reg_t r;
      cmd_imm_t i;
   } cmd_word_u;

   // Write request towards the arbiter.
   typedef struct packed
   {
      logic                     valid;
      logic [`RF_ADDR_SIZE-1:0] addr;
      logic [`RF_WIDTH-1:0]     data;
   } rf_wr_req_t;

   // Status word as seen by the host.
   typedef struct packed
   {
      logic [15:0] rsvd_hi;
      logic [7:0]  count;
      logic [6:0]  rsvd_lo;
      logic        busy;
   } stat_t;

endpackage

//--- rtl/wr_arbiter.sv
`timescale 1ns/100ps
`include "rfm_macros.svh"

module wr_arbiter
(
   input  logic                     clk,
   input  logic                     reset,
   input  rfm_pkg::rf_wr_req_t      host_req,
   input  rfm_pkg::rf_wr_req_t      exec_req,
   output logic                     host_gnt,
   output logic                     exec_gnt,
   output logic                     wen,
   output logic [`RF_ADDR_SIZE-1:0] wa,
   output logic [`RF_WIDTH-1:0]     din
);

   import rfm_pkg::*;

   // Set when the host won the last grant.
   logic last_host;

   // A lone request wins at once.
   // On a tie the loser of the last grant goes first.
   assign host_gnt = host_req.valid & (~exec_req.valid | ~last_host);
   assign exec_gnt = exec_req.valid & (~host_req.valid | last_host);

   // Last winner.
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         last_host <= 1'b0;
      end
      else if (host_gnt)
      begin
         last_host <= 1'b1;
      end
      else if (exec_gnt)
      begin
         last_host <= 1'b0;
      end
   end

   // Write port steering.
   assign wen = host_gnt | exec_gnt;
   assign wa  = host_gnt ? host_req.addr : exec_req.addr;
   assign din = host_gnt ? host_req.data : exec_req.data;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register file subsystem testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sim_rf_subsys
LOG=sim.log

verilator --binary --timing \
   --timescale 1ns/100ps \
   --top-module tb_rf_subsys \
   -Mdir "${OBJ_DIR}" \
   -o "${SIM_BIN}" \
   -f project.f
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

"./${OBJ_DIR}/${SIM_BIN}" > "${LOG}" 2>&1
sim_status=$?
cat "${LOG}"
if [ ${sim_status} -ne 0 ]; then
   echo "Simulation exited with status ${sim_status}"
   exit 1
fi

if grep -qx "Regression passed" "${LOG}"; then
   exit 0
fi

echo "Pass message not found in ${LOG}"
exit 1

//--- verification/tb_rf_subsys.sv
`timescale 1ns/100ps
`include "rfm_macros.svh"

module tb_rf_subsys;

   // Table entry kinds.
   localparam logic [1:0] k_wr   = 2'd0;
   localparam logic [1:0] k_rd   = 2'd1;
   localparam logic [1:0] k_cmd  = 2'd2;
   localparam logic [1:0] k_poll = 2'd3;

   // Opcodes as listed in the register map.
   localparam logic [3:0] op_add  = 4'd0;
   localparam logic [3:0] op_sub  = 4'd1;
   localparam logic [3:0] op_and  = 4'd2;
   localparam logic [3:0] op_or   = 4'd3;
   localparam logic [3:0] op_xor  = 4'd4;
   localparam logic [3:0] op_mac  = 4'd5;
   localparam logic [3:0] op_ldi  = 4'd8;
   localparam logic [3:0] op_ldhi = 4'd9;

   // Wait limits in clock cycles and status reads.
   localparam int max_wait  = 100;
   localparam int max_polls = 50;

   // One stimulus line.
   typedef struct packed
   {
      logic [1:0]  kind;
      logic [2:0]  test;
      logic [11:0] addr;
      logic [31:0] data;
      logic [31:0] exp;
      logic        err;
   } entry_t;

   logic clk;
   logic reset;
   logic psel;
   logic penable;
   logic pwrite;
   logic [`APB_ADDR_W-1:0] paddr;
   logic [`RF_WIDTH-1:0] pwdata;
   logic [`RF_WIDTH-1:0] prdata;
   logic pready;
   logic pslverr;

   entry_t table_q[$];
   string  test_name [0:7];

   // Reference model state.
   logic [31:0] model_reg [0:15];
   logic [7:0]  model_count;

   integer seed = 49460;
   int     checks;
   int     errors;
   int     tests;
   logic   timed_out;

   rf_subsys_top i_rf_subsys_top
   (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Checker and bus tasks.
   //////////////////////////////////////////////////////////////////////

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One APB transfer, setup then access until pready.
   // The next rising edge ends it and carries the next setup,
   // so transfers run back to back.
   task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int   cyc;
      logic done;
      cyc   = 0;
      done  = 1'b0;
      rdata = '0;
      err   = 1'b0;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      // Outputs settle by the falling edge.
      while (!done && cyc < max_wait)
      begin
         @(negedge clk);
         if (pready)
         begin
            done  = 1'b1;
            rdata = prdata;
            err   = pslverr;
         end
         else
         begin
            cyc++;
         end
      end
      if (!done)
      begin
         $display("Timeout: no pready for address %h after %0d cycles", addr, max_wait);
         timed_out = 1'b1;
      end
   endtask

   // Bus back to idle on the edge that ends the last transfer.
   task automatic bus_idle;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Status reads until busy drops.
   task automatic poll_status(output logic [31:0] stat_word);
      int   polls;
      logic err;
      polls     = 0;
      stat_word = 32'h1;
      while (stat_word[0] && polls < max_polls && !timed_out)
      begin
         apb_xfer(1'b0, `RF_STAT_OFS, 32'h0, stat_word, err);
         check({31'b0, err}, 32'h0, "pslverr on status read");
         polls++;
      end
      if (stat_word[0] && !timed_out)
      begin
         $display("Timeout: busy still set after %0d status reads", max_polls);
         timed_out = 1'b1;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model and table building.
   //////////////////////////////////////////////////////////////////////

   task automatic add_entry(input logic [1:0] kind, input logic [2:0] test,
                            input logic [11:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input logic err);
      entry_t e;
      e.kind = kind;
      e.test = test;
      e.addr = addr;
      e.data = data;
      e.exp  = exp;
      e.err  = err;
      table_q.push_back(e);
   endtask

   // Register n sits at byte 4*n.
   function automatic logic [11:0] reg_addr(input int n);
      return 12'(n * 4);
   endfunction

   // Command executed on the model, fields cut straight from the word.
   task automatic model_exec(input logic [31:0] w);
      logic [3:0]  op;
      logic [3:0]  rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [63:0] prod;
      op   = w[31:28];
      rd   = w[27:24];
      a    = model_reg[w[23:20]];
      b    = model_reg[w[19:16]];
      prod = {32'b0, a} * {32'b0, b};
      case (op)
         op_add:  model_reg[rd] = a + b;
         op_sub:  model_reg[rd] = a - b;
         op_and:  model_reg[rd] = a & b;
         op_or:   model_reg[rd] = a | b;
         op_xor:  model_reg[rd] = a ^ b;
         op_mac:  model_reg[rd] = model_reg[rd] + prod[31:0];
         op_ldi:  model_reg[rd] = {{16{w[15]}}, w[15:0]};
         op_ldhi: model_reg[rd] = {w[15:0], model_reg[rd][15:0]};
         default: model_reg[rd] = model_reg[rd];
      endcase
      model_count = model_count + 8'd1;
   endtask

   // Legal command, model updated alongside.
   task automatic add_cmd(input logic [2:0] test, input logic [31:0] w);
      add_entry(k_cmd, test, `RF_CMD_OFS, w, 32'h0, 1'b0);
      model_exec(w);
   endtask

   task automatic add_read(input logic [2:0] test, input int n);
      add_entry(k_rd, test, reg_addr(n), 32'h0, model_reg[n], 1'b0);
   endtask

   // Expected status has busy clear.
   task automatic add_poll(input logic [2:0] test);
      add_entry(k_poll, test, `RF_STAT_OFS, 32'h0, {16'h0, model_count, 8'h0}, 1'b0);
   endtask

   task automatic build_table;
      logic [31:0] v;
      logic [3:0]  alu_ops [0:4];
      alu_ops = '{op_add, op_sub, op_and, op_or, op_xor};
      for (int n = 0; n < 16; n++)
      begin
         model_reg[n] = '0;
      end
      model_count = '0;

      // Reset values.
      for (int n = 0; n < 16; n++)
      begin
         add_read(3'd1, n);
      end
      add_poll(3'd1);

      // Random fill and readback.
      for (int n = 0; n < 16; n++)
      begin
         v = $random(seed);
         add_entry(k_wr, 3'd2, reg_addr(n), v, 32'h0, 1'b0);
         model_reg[n] = v;
      end
      for (int n = 0; n < 16; n++)
      begin
         add_read(3'd2, n);
      end

      // ALU ops, rd = 1..5 from pairs further up.
      for (int k = 0; k < 5; k++)
      begin
         add_cmd(3'd3, {alu_ops[k], 4'(k + 1), 4'(k + 6), 4'(15 - k), 16'h0});
         add_poll(3'd3);
         add_read(3'd3, k + 1);
      end

      // MAC, then a negative LDI and LDHI on top of it.
      add_cmd(3'd4, {op_mac, 4'd12, 4'd13, 4'd14, 16'h0});
      add_poll(3'd4);
      add_read(3'd4, 12);
      add_cmd(3'd4, {op_ldi, 4'd7, 8'h00, 16'h8123});
      add_poll(3'd4);
      add_read(3'd4, 7);
      add_cmd(3'd4, {op_ldhi, 4'd7, 8'h00, 16'hbeef});
      add_poll(3'd4);
      add_read(3'd4, 7);

      // Error responses with no side effect.
      add_entry(k_cmd, 3'd5, `RF_CMD_OFS, {4'd6, 4'd0, 4'd1, 4'd2, 16'h0}, 32'h0, 1'b1);
      add_entry(k_wr, 3'd5, 12'h100, 32'hdead_beef, 32'h0, 1'b1);
      add_entry(k_wr, 3'd5, `RF_STAT_OFS, 32'h0000_ff01, 32'h0, 1'b1);
      add_entry(k_rd, 3'd5, 12'h002, 32'h0, 32'h0, 1'b1);
      add_poll(3'd5);
      add_read(3'd5, 0);
      add_read(3'd5, 1);

      // Back to back, the second one depends on the first.
      add_cmd(3'd6, {op_add, 4'd8, 4'd9, 4'd10, 16'h0});
      add_cmd(3'd6, {op_xor, 4'd11, 4'd8, 4'd15, 16'h0});
      add_poll(3'd6);
      add_read(3'd6, 8);
      add_read(3'd6, 11);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence.
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      entry_t      e;
      logic [31:0] rdata;
      logic        err;
      int          errs_at_start;
      logic        last_of_test;

      reset     = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      timed_out = 1'b0;
      errs_at_start = 0;
      test_name = '{"", "reset values", "register readback", "ALU commands",
                    "MAC LDI LDHI", "error responses", "stalled command", ""};

      build_table();
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      for (int k = 0; k < table_q.size() && !timed_out; k++)
      begin
         e = table_q[k];
         case (e.kind)
            k_wr, k_cmd:
            begin
               apb_xfer(1'b1, e.addr, e.data, rdata, err);
               check({31'b0, err}, {31'b0, e.err}, "pslverr on write");
            end
            k_rd:
            begin
               apb_xfer(1'b0, e.addr, 32'h0, rdata, err);
               check({31'b0, err}, {31'b0, e.err}, "pslverr on read");
               if (!e.err)
               begin
                  check(rdata, e.exp, $sformatf("read data at %h", e.addr));
               end
            end
            default:
            begin
               poll_status(rdata);
               if (!timed_out)
               begin
                  check(rdata, e.exp, "status word");
               end
            end
         endcase
         last_of_test = (k == table_q.size() - 1) || (table_q[k + 1].test != e.test);
         if (last_of_test || timed_out)
         begin
            tests++;
            $display("Test %0d %s: %s, %0d errors", e.test, test_name[e.test],
                     (errors == errs_at_start && !timed_out) ? "ok" : "FAILED",
                     errors - errs_at_start);
            errs_at_start = errors;
         end
      end
      bus_idle();

      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0 && !timed_out)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
